/* common/fuse_filter_pkg.sv */
package fuse_filter_pkg;

    // ----------------------------------------
    // Bus and register geometry
    // ----------------------------------------

    // Only the low address bits select a direct-access register.
    localparam int DAI_ADDR_W = 12;
    localparam int DATA_W     = 32;
    localparam int USER_W     = 32;

    localparam logic [DAI_ADDR_W-1:0] DAI_WDATA0_OFFSET  = 12'h008;
    localparam logic [DAI_ADDR_W-1:0] DAI_WDATA1_OFFSET  = 12'h00C;
    localparam logic [DAI_ADDR_W-1:0] DAI_ADDRESS_OFFSET = 12'h010;
    localparam logic [DAI_ADDR_W-1:0] DAI_CMD_OFFSET     = 12'h014;

    // ----------------------------------------
    // Command and ownership encodings
    // ----------------------------------------

    // The command register takes a one-hot command in its low bits.
    typedef enum logic [3:0] {
        DaiOther   = 4'h0,
        DaiRead    = 4'h1,
        DaiWrite   = 4'h2,
        DaiDigest  = 4'h4,
        DaiZeroize = 4'h8
    } dai_cmd_e;

    typedef enum logic {
        OWNER_CALIPTRA = 1'b0,
        OWNER_MCU      = 1'b1
    } access_owner_e;

    typedef struct packed {
        logic [DATA_W-1:0] lower_addr;
        logic [DATA_W-1:0] upper_addr;
        access_owner_e     owner;
    } access_entry_t;

    // ----------------------------------------
    // Access table and secret range
    // ----------------------------------------

    localparam int ACCESS_TABLE_RANGES = 3;

    // Both bounds of every range are inclusive.
    localparam access_entry_t ACCESS_TABLE [0:ACCESS_TABLE_RANGES-1] = '{
        '{lower_addr: 32'h0000_0000, upper_addr: 32'h0000_00FF, owner: OWNER_CALIPTRA},
        '{lower_addr: 32'h0000_0100, upper_addr: 32'h0000_02FF, owner: OWNER_MCU},
        '{lower_addr: 32'h0000_0300, upper_addr: 32'h0000_03FF, owner: OWNER_MCU}
    };

    // Fuses in this window hold secrets and get the debug and zeroize rules.
    localparam logic [DATA_W-1:0] SECRET_LOWER_ADDR = 32'h0000_0040;
    localparam logic [DATA_W-1:0] SECRET_UPPER_ADDR = 32'h0000_007F;

    // ----------------------------------------
    // Sequence states
    // ----------------------------------------

    typedef enum logic [2:0] {
        ST_RESET,
        ST_IDLE,
        ST_WDATA_ADDR,
        ST_WDATA,
        ST_FUSE_ADDR_ADDR,
        ST_FUSE_ADDR_WR,
        ST_CMD_ADDR,
        ST_DISCARD
    } filter_state_e;

endpackage

/* logic/dai_bus_decode.sv */
`timescale 1ns/1ns

module dai_bus_decode (
    input  logic                                aw_valid_i,
    input  logic                                aw_ready_i,
    input  logic [fuse_filter_pkg::DATA_W-1:0]  aw_addr_i,
    input  logic                                w_valid_i,
    input  logic                                w_ready_i,
    input  logic [fuse_filter_pkg::DATA_W-1:0]  w_data_i,
    output logic                                wdata0_aw_o,
    output logic                                wdata1_aw_o,
    output logic                                addr_aw_o,
    output logic                                cmd_aw_o,
    output logic                                w_beat_o,
    output fuse_filter_pkg::dai_cmd_e           fuse_cmd_o
);
    import fuse_filter_pkg::*;

    logic                  aw_hs;
    logic [DAI_ADDR_W-1:0] reg_offset;

    // The filter only watches the bus, so a transfer counts once both
    // sides of the handshake agree in the same cycle.
    assign aw_hs      = aw_valid_i && aw_ready_i;
    assign w_beat_o   = w_valid_i && w_ready_i;
    assign reg_offset = aw_addr_i[DAI_ADDR_W-1:0];

    assign wdata0_aw_o = aw_hs && (reg_offset == DAI_WDATA0_OFFSET);
    assign wdata1_aw_o = aw_hs && (reg_offset == DAI_WDATA1_OFFSET);
    assign addr_aw_o   = aw_hs && (reg_offset == DAI_ADDRESS_OFFSET);
    assign cmd_aw_o    = aw_hs && (reg_offset == DAI_CMD_OFFSET);

    // Anything that is not exactly one of the four known commands
    // is treated as a command that no rule applies to.
    always_comb begin
        case (w_data_i[3:0])
            4'h1:    fuse_cmd_o = DaiRead;
            4'h2:    fuse_cmd_o = DaiWrite;
            4'h4:    fuse_cmd_o = DaiDigest;
            4'h8:    fuse_cmd_o = DaiZeroize;
            default: fuse_cmd_o = DaiOther;
        endcase
    end

endmodule

/* logic/access_table_check.sv */
`timescale 1ns/1ns

module access_table_check (
    input  logic [fuse_filter_pkg::DATA_W-1:0] fuse_addr_i,
    input  logic [fuse_filter_pkg::USER_W-1:0] cmd_id_i,
    input  logic [fuse_filter_pkg::USER_W-1:0] cptra_user_i,
    input  logic [fuse_filter_pkg::USER_W-1:0] mcu_user_i,
    output logic                               table_ok_o
);
    import fuse_filter_pkg::*;

    logic [ACCESS_TABLE_RANGES-1:0] entry_hit;

    // ----------------------------------------
    // Per-entry range and owner match
    // ----------------------------------------

    for (genvar g = 0; g < ACCESS_TABLE_RANGES; g++) begin : g_entry
        logic [USER_W-1:0] owner_id;
        logic              in_range;

        // Each entry names an owner, which maps to one of the strap IDs.
        assign owner_id = (ACCESS_TABLE[g].owner == OWNER_MCU) ? mcu_user_i : cptra_user_i;

        assign in_range = (fuse_addr_i >= ACCESS_TABLE[g].lower_addr) &&
                          (fuse_addr_i <= ACCESS_TABLE[g].upper_addr);

        assign entry_hit[g] = in_range && (cmd_id_i == owner_id);
    end

    // Ranges may overlap, so any single matching entry grants access.
    assign table_ok_o = |entry_hit;

endmodule

/* fuse_filter/dai_id_records.sv */
`timescale 1ns/1ns

module dai_id_records (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic [fuse_filter_pkg::USER_W-1:0] aw_user_i,
    input  logic [fuse_filter_pkg::DATA_W-1:0] w_data_i,
    input  logic                               latch_id0_i,
    input  logic                               latch_id1_i,
    input  logic                               latch_addr_id_i,
    input  logic                               latch_cmd_id_i,
    input  logic                               latch_fuse_addr_i,
    input  logic                               clear_records_i,
    output logic [fuse_filter_pkg::DATA_W-1:0] fuse_addr_o,
    output logic [fuse_filter_pkg::USER_W-1:0] cmd_id_o,
    output logic                               secret_o,
    output logic                               all_same_id_o,
    output logic                               addr_cmd_same_id_o
);
    import fuse_filter_pkg::*;

    logic [USER_W-1:0] data_id0_q;
    logic [USER_W-1:0] data_id1_q;
    logic [USER_W-1:0] addr_id_q;

    // Every captured value shows up one cycle after its handshake.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_id0_q  <= '0;
            data_id1_q  <= '0;
            addr_id_q   <= '0;
            cmd_id_o    <= '0;
            fuse_addr_o <= '0;
            secret_o    <= 1'b0;
        end else if (clear_records_i) begin
            data_id0_q  <= '0;
            data_id1_q  <= '0;
            addr_id_q   <= '0;
            cmd_id_o    <= '0;
            fuse_addr_o <= '0;
            secret_o    <= 1'b0;
        end else begin
            if (latch_id0_i) data_id0_q <= aw_user_i;
            if (latch_id1_i) data_id1_q <= aw_user_i;
            if (latch_addr_id_i) addr_id_q <= aw_user_i;
            if (latch_cmd_id_i) cmd_id_o <= aw_user_i;
            if (latch_fuse_addr_i) begin
                fuse_addr_o <= w_data_i;
                secret_o    <= (w_data_i >= SECRET_LOWER_ADDR) &&
                               (w_data_i <= SECRET_UPPER_ADDR);
            end
        end
    end

    // Data word 1 only has to match for secret fuses, which are written as
    // two words. Everything else is a single word plus address and command.
    assign all_same_id_o = ((data_id1_q == data_id0_q) || !secret_o) &&
                           (data_id0_q == addr_id_q) &&
                           (addr_id_q == cmd_id_o);

    assign addr_cmd_same_id_o = (addr_id_q == cmd_id_o);

    // The FSM never clears the records in a cycle where it also captures one.
    a_no_clear_with_latch: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        clear_records_i |-> !(latch_id0_i || latch_id1_i || latch_addr_id_i ||
                              latch_cmd_id_i || latch_fuse_addr_i));

endmodule

/* fuse_filter/dai_sequence_fsm.sv */
`timescale 1ns/1ns

module dai_sequence_fsm (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      init_done_i,
    input  logic                      debug_mode_i,
    input  logic                      fips_zeroize_i,
    input  logic                      wdata0_aw_i,
    input  logic                      wdata1_aw_i,
    input  logic                      addr_aw_i,
    input  logic                      cmd_aw_i,
    input  logic                      w_beat_i,
    input  fuse_filter_pkg::dai_cmd_e fuse_cmd_i,
    input  logic                      table_ok_i,
    input  logic                      secret_i,
    input  logic                      all_same_id_i,
    input  logic                      addr_cmd_same_id_i,
    input  logic                      discarded_fuse_i,
    output logic                      latch_id0_o,
    output logic                      latch_id1_o,
    output logic                      latch_addr_id_o,
    output logic                      latch_cmd_id_o,
    output logic                      latch_fuse_addr_o,
    output logic                      clear_records_o,
    output logic                      discard_fuse_o
);
    import fuse_filter_pkg::*;

    filter_state_e state_q;
    filter_state_e state_d;
    logic          verdict_discard;
    logic          discard_d;

    // ----------------------------------------
    // Verdict rules
    // ----------------------------------------

    // First matching rule wins. Reads are never blocked.
    always_comb begin
        verdict_discard = 1'b0;
        if (fuse_cmd_i == DaiRead) begin
            verdict_discard = 1'b0;
        end else if (debug_mode_i && secret_i) begin
            verdict_discard = 1'b1;
        end else begin
            case (fuse_cmd_i)
                DaiWrite:   verdict_discard = !table_ok_i || !all_same_id_i;
                DaiDigest:  verdict_discard = !table_ok_i || !addr_cmd_same_id_i;
                DaiZeroize: verdict_discard = (secret_i && !fips_zeroize_i) ||
                                              !table_ok_i || !addr_cmd_same_id_i;
                default:    verdict_discard = 1'b0;
            endcase
        end
    end

    // ----------------------------------------
    // Sequence tracking
    // ----------------------------------------

    always_comb begin
        state_d           = state_q;
        latch_id0_o       = 1'b0;
        latch_id1_o       = 1'b0;
        latch_addr_id_o   = 1'b0;
        latch_cmd_id_o    = 1'b0;
        latch_fuse_addr_o = 1'b0;
        clear_records_o   = 1'b0;
        discard_d         = 1'b0;
        case (state_q)
            ST_RESET: begin
                clear_records_o = 1'b1;
                if (init_done_i) state_d = ST_IDLE;
            end
            ST_IDLE: begin
                if (wdata0_aw_i) begin
                    latch_id0_o = 1'b1;
                    state_d     = ST_WDATA_ADDR;
                end else if (wdata1_aw_i) begin
                    latch_id1_o = 1'b1;
                    state_d     = ST_WDATA_ADDR;
                end else if (addr_aw_i) begin
                    latch_addr_id_o = 1'b1;
                    state_d         = ST_FUSE_ADDR_ADDR;
                end else if (cmd_aw_i) begin
                    latch_cmd_id_o = 1'b1;
                    state_d        = ST_CMD_ADDR;
                end
            end
            ST_WDATA_ADDR: begin
                if (w_beat_i) state_d = ST_WDATA;
            end
            // After a data word or the fuse address, the next register write
            // can be any of the four, with the address register taking the lead.
            ST_WDATA, ST_FUSE_ADDR_WR: begin
                if (addr_aw_i) begin
                    latch_addr_id_o = 1'b1;
                    state_d         = ST_FUSE_ADDR_ADDR;
                end else if (wdata0_aw_i) begin
                    latch_id0_o = 1'b1;
                    state_d     = ST_WDATA_ADDR;
                end else if (wdata1_aw_i) begin
                    latch_id1_o = 1'b1;
                    state_d     = ST_WDATA_ADDR;
                end else if (cmd_aw_i) begin
                    latch_cmd_id_o = 1'b1;
                    state_d        = ST_CMD_ADDR;
                end
            end
            ST_FUSE_ADDR_ADDR: begin
                if (w_beat_i) begin
                    latch_fuse_addr_o = 1'b1;
                    state_d           = ST_FUSE_ADDR_WR;
                end
            end
            ST_CMD_ADDR: begin
                if (w_beat_i) begin
                    discard_d = verdict_discard;
                    state_d   = verdict_discard ? ST_DISCARD : ST_IDLE;
                end
            end
            // Bus traffic is ignored until the fuse controller confirms the discard.
            ST_DISCARD: begin
                discard_d = 1'b1;
                if (discarded_fuse_i) state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q        <= ST_RESET;
            discard_fuse_o <= 1'b0;
        end else begin
            state_q        <= state_d;
            discard_fuse_o <= discard_d;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // The decoder compares one address with distinct offsets.
    a_decode_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({wdata0_aw_i, wdata1_aw_i, addr_aw_i, cmd_aw_i}));

    a_latch_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({latch_id0_o, latch_id1_o, latch_addr_id_o, latch_cmd_id_o,
                  latch_fuse_addr_o}));

    // A discard can only start from the command beat of a full sequence.
    a_discard_from_verdict: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(discard_fuse_o) |-> $past(state_q == ST_CMD_ADDR && w_beat_i));

endmodule

/* fuse_filter/fuse_filter_top.sv */
`timescale 1ns/1ns

module fuse_filter_top (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               init_done_i,
    input  logic                               debug_mode_i,
    input  logic                               fips_zeroize_i,
    input  logic [fuse_filter_pkg::USER_W-1:0] cptra_user_i,
    input  logic [fuse_filter_pkg::USER_W-1:0] mcu_user_i,
    input  logic                               aw_valid_i,
    input  logic                               aw_ready_i,
    input  logic [fuse_filter_pkg::DATA_W-1:0] aw_addr_i,
    input  logic [fuse_filter_pkg::USER_W-1:0] aw_user_i,
    input  logic                               w_valid_i,
    input  logic                               w_ready_i,
    input  logic [fuse_filter_pkg::DATA_W-1:0] w_data_i,
    input  logic                               discarded_fuse_i,
    output logic                               discard_fuse_o
);
    import fuse_filter_pkg::*;

    logic              wdata0_aw;
    logic              wdata1_aw;
    logic              addr_aw;
    logic              cmd_aw;
    logic              w_beat;
    dai_cmd_e          fuse_cmd;
    logic              latch_id0;
    logic              latch_id1;
    logic              latch_addr_id;
    logic              latch_cmd_id;
    logic              latch_fuse_addr;
    logic              clear_records;
    logic [DATA_W-1:0] fuse_addr;
    logic [USER_W-1:0] cmd_id;
    logic              secret;
    logic              all_same_id;
    logic              addr_cmd_same_id;
    logic              table_ok;

    dai_bus_decode u_decode (
        .aw_valid_i  (aw_valid_i),
        .aw_ready_i  (aw_ready_i),
        .aw_addr_i   (aw_addr_i),
        .w_valid_i   (w_valid_i),
        .w_ready_i   (w_ready_i),
        .w_data_i    (w_data_i),
        .wdata0_aw_o (wdata0_aw),
        .wdata1_aw_o (wdata1_aw),
        .addr_aw_o   (addr_aw),
        .cmd_aw_o    (cmd_aw),
        .w_beat_o    (w_beat),
        .fuse_cmd_o  (fuse_cmd)
    );

    dai_id_records u_records (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .aw_user_i          (aw_user_i),
        .w_data_i           (w_data_i),
        .latch_id0_i        (latch_id0),
        .latch_id1_i        (latch_id1),
        .latch_addr_id_i    (latch_addr_id),
        .latch_cmd_id_i     (latch_cmd_id),
        .latch_fuse_addr_i  (latch_fuse_addr),
        .clear_records_i    (clear_records),
        .fuse_addr_o        (fuse_addr),
        .cmd_id_o           (cmd_id),
        .secret_o           (secret),
        .all_same_id_o      (all_same_id),
        .addr_cmd_same_id_o (addr_cmd_same_id)
    );

    access_table_check u_table (
        .fuse_addr_i  (fuse_addr),
        .cmd_id_i     (cmd_id),
        .cptra_user_i (cptra_user_i),
        .mcu_user_i   (mcu_user_i),
        .table_ok_o   (table_ok)
    );

    dai_sequence_fsm u_fsm (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .init_done_i        (init_done_i),
        .debug_mode_i       (debug_mode_i),
        .fips_zeroize_i     (fips_zeroize_i),
        .wdata0_aw_i        (wdata0_aw),
        .wdata1_aw_i        (wdata1_aw),
        .addr_aw_i          (addr_aw),
        .cmd_aw_i           (cmd_aw),
        .w_beat_i           (w_beat),
        .fuse_cmd_i         (fuse_cmd),
        .table_ok_i         (table_ok),
        .secret_i           (secret),
        .all_same_id_i      (all_same_id),
        .addr_cmd_same_id_i (addr_cmd_same_id),
        .discarded_fuse_i   (discarded_fuse_i),
        .latch_id0_o        (latch_id0),
        .latch_id1_o        (latch_id1),
        .latch_addr_id_o    (latch_addr_id),
        .latch_cmd_id_o     (latch_cmd_id),
        .latch_fuse_addr_o  (latch_fuse_addr),
        .clear_records_o    (clear_records),
        .discard_fuse_o     (discard_fuse_o)
    );

endmodule

/* dv/fuse_filter_tb.sv */
`timescale 1ns/1ns

module fuse_filter_tb;

    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] DAI_BASE       = 32'h3000_0000;
    localparam logic [11:0] OFS_WDATA0     = 12'h008;
    localparam logic [11:0] OFS_WDATA1     = 12'h00C;
    localparam logic [11:0] OFS_ADDRESS    = 12'h010;
    localparam logic [11:0] OFS_CMD        = 12'h014;
    localparam logic [3:0]  CMD_READ       = 4'h1;
    localparam logic [3:0]  CMD_WRITE      = 4'h2;
    localparam logic [3:0]  CMD_DIGEST     = 4'h4;
    localparam logic [3:0]  CMD_ZEROIZE    = 4'h8;
    localparam logic [31:0] CPTRA_ID       = 32'hC0DE_0001;
    localparam logic [31:0] MCU_ID         = 32'h0000_0D0C;
    localparam logic [31:0] ROGUE_ID       = 32'h0BAD_0000;

    logic        clk;
    logic        rst_n;
    logic        init_done;
    logic        debug_mode;
    logic        fips_zeroize;
    logic [31:0] cptra_user;
    logic [31:0] mcu_user;
    logic        aw_valid;
    logic        aw_ready;
    logic [31:0] aw_addr;
    logic [31:0] aw_user;
    logic        w_valid;
    logic        w_ready;
    logic [31:0] w_data;
    logic        discarded_fuse;
    logic        discard_fuse;

    logic [31:0] lfsr_q;
    logic [31:0] model_id1;
    int          cycle_count;
    int          checks;
    int          errors;

    fuse_filter_top UUT (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .init_done_i      (init_done),
        .debug_mode_i     (debug_mode),
        .fips_zeroize_i   (fips_zeroize),
        .cptra_user_i     (cptra_user),
        .mcu_user_i       (mcu_user),
        .aw_valid_i       (aw_valid),
        .aw_ready_i       (aw_ready),
        .aw_addr_i        (aw_addr),
        .aw_user_i        (aw_user),
        .w_valid_i        (w_valid),
        .w_ready_i        (w_ready),
        .w_data_i         (w_data),
        .discarded_fuse_i (discarded_fuse),
        .discard_fuse_o   (discard_fuse)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles before the tests finished.", cycle_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ----------------------------------------
    // Random bits and reference model
    // ----------------------------------------

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [31:0] pick_id(input logic [1:0] sel);
        case (sel)
            2'd1:    return MCU_ID;
            2'd3:    return ROGUE_ID;
            default: return CPTRA_ID;
        endcase
    endfunction

    // Verdict rules in order. The first rule that matches decides.
    function automatic logic predict_discard(input logic [3:0] cmd_bits,
                                             input logic [31:0] fuse_addr,
                                             input logic [31:0] id0,
                                             input logic [31:0] id1,
                                             input logic [31:0] addr_id,
                                             input logic [31:0] cmd_id);
        logic secret;
        logic table_ok;
        logic pair_same;
        logic all_same;
        secret    = (fuse_addr >= 32'h040) && (fuse_addr <= 32'h07F);
        table_ok  = ((fuse_addr <= 32'h0FF) && (cmd_id == CPTRA_ID)) ||
                    ((fuse_addr >= 32'h100) && (fuse_addr <= 32'h3FF) && (cmd_id == MCU_ID));
        pair_same = (addr_id == cmd_id);
        all_same  = ((id1 == id0) || !secret) && (id0 == addr_id) && pair_same;
        if (cmd_bits == CMD_READ) return 1'b0;
        if (debug_mode && secret) return 1'b1;
        case (cmd_bits)
            CMD_WRITE:   return !table_ok || !all_same;
            CMD_DIGEST:  return !table_ok || !pair_same;
            CMD_ZEROIZE: return (secret && !fips_zeroize) || !table_ok || !pair_same;
            default:     return 1'b0;
        endcase
    endfunction

    // ----------------------------------------
    // Bus driver and response checks
    // ----------------------------------------

    // One register write. Address handshake first, then the data beat, each
    // with a random ready stall of up to one cycle.
    task automatic write_reg(input logic [11:0] offset, input logic [31:0] user,
                             input logic [31:0] data);
        logic [31:0] stall;
        aw_addr  = DAI_BASE | {20'h0, offset};
        aw_user  = user;
        aw_valid = 1'b1;
        aw_ready = 1'b0;
        draw_bits(1, stall);
        repeat (stall) @(negedge clk);
        aw_ready = 1'b1;
        @(negedge clk);
        aw_valid = 1'b0;
        aw_ready = 1'b0;
        w_data   = data;
        w_valid  = 1'b1;
        w_ready  = 1'b0;
        draw_bits(1, stall);
        repeat (stall) @(negedge clk);
        w_ready = 1'b1;
        @(negedge clk);
        w_valid = 1'b0;
        w_ready = 1'b0;
    endtask

    task automatic expect_level(input string label, input logic expected);
        checks++;
        if (discard_fuse !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s: discard_fuse_o expected %0b, got %0b",
                     $time, label, expected, discard_fuse);
        end
    endtask

    // Called one edge after the command beat.
    task automatic check_verdict(input string label, input logic expected, input int hold);
        expect_level(label, expected);
        if (expected || discard_fuse) begin
            repeat (hold) begin
                @(negedge clk);
                expect_level(label, expected);
            end
            discarded_fuse = 1'b1;
            @(negedge clk);
            discarded_fuse = 1'b0;
            expect_level(label, expected);
            @(negedge clk);
            expect_level(label, 1'b0);
        end
    endtask

    task automatic run_case(input string label, input logic [31:0] fuse_addr,
                            input logic [3:0] cmd_bits, input logic [31:0] id0,
                            input logic [31:0] id1, input logic send1,
                            input logic [31:0] addr_id, input logic [31:0] cmd_id,
                            input logic expected, input int hold);
        write_reg(OFS_WDATA0, id0, ~fuse_addr);
        if (send1) begin
            write_reg(OFS_WDATA1, id1, fuse_addr ^ 32'h5A5A_5A5A);
            // The data word 1 ID stays recorded for later commands that skip it.
            if (init_done) model_id1 = id1;
        end
        write_reg(OFS_ADDRESS, addr_id, fuse_addr);
        write_reg(OFS_CMD, cmd_id, {28'h0, cmd_bits});
        check_verdict(label, expected, hold);
    endtask

    // ----------------------------------------
    // Directed and random tests
    // ----------------------------------------

    task automatic test_reset();
        expect_level("after reset", 1'b0);
        run_case("before init", 32'h180, CMD_WRITE, CPTRA_ID, CPTRA_ID, 1'b0,
                 CPTRA_ID, CPTRA_ID, 1'b0, 0);
        @(negedge clk);
        expect_level("before init", 1'b0);
        init_done = 1'b1;
        @(negedge clk);
    endtask

    task automatic test_allowed();
        run_case("mcu write 0x180", 32'h180, CMD_WRITE, MCU_ID, MCU_ID, 1'b0,
                 MCU_ID, MCU_ID, 1'b0, 0);
        run_case("caliptra write 0x020", 32'h020, CMD_WRITE, CPTRA_ID, CPTRA_ID, 1'b0,
                 CPTRA_ID, CPTRA_ID, 1'b0, 0);
        run_case("read 0x3f0", 32'h3F0, CMD_READ, ROGUE_ID, ROGUE_ID, 1'b0,
                 CPTRA_ID, ROGUE_ID, 1'b0, 0);
    endtask

    task automatic test_table_violation();
        run_case("caliptra write 0x180", 32'h180, CMD_WRITE, CPTRA_ID, CPTRA_ID, 1'b0,
                 CPTRA_ID, CPTRA_ID, 1'b1, 5);
    endtask

    task automatic test_id_consistency();
        run_case("write id0 mismatch", 32'h180, CMD_WRITE, CPTRA_ID, MCU_ID, 1'b0,
                 MCU_ID, MCU_ID, 1'b1, 2);
        run_case("digest id0 mismatch", 32'h180, CMD_DIGEST, CPTRA_ID, MCU_ID, 1'b0,
                 MCU_ID, MCU_ID, 1'b0, 0);
        run_case("secret id1 mismatch", 32'h050, CMD_WRITE, CPTRA_ID, MCU_ID, 1'b1,
                 CPTRA_ID, CPTRA_ID, 1'b1, 2);
        run_case("public id1 mismatch", 32'h020, CMD_WRITE, CPTRA_ID, MCU_ID, 1'b1,
                 CPTRA_ID, CPTRA_ID, 1'b0, 0);
    endtask

    task automatic test_secret_rules();
        debug_mode = 1'b1;
        run_case("debug write 0x050", 32'h050, CMD_WRITE, CPTRA_ID, CPTRA_ID, 1'b1,
                 CPTRA_ID, CPTRA_ID, 1'b1, 1);
        run_case("debug read 0x050", 32'h050, CMD_READ, CPTRA_ID, CPTRA_ID, 1'b0,
                 CPTRA_ID, CPTRA_ID, 1'b0, 0);
        debug_mode = 1'b0;
        run_case("zeroize 0x050 fips low", 32'h050, CMD_ZEROIZE, CPTRA_ID, CPTRA_ID, 1'b0,
                 CPTRA_ID, CPTRA_ID, 1'b1, 3);
        fips_zeroize = 1'b1;
        run_case("zeroize 0x050 fips high", 32'h050, CMD_ZEROIZE, CPTRA_ID, CPTRA_ID, 1'b0,
                 CPTRA_ID, CPTRA_ID, 1'b0, 0);
        fips_zeroize = 1'b0;
    endtask

    // Most steps reuse one base ID, so agreeing sequences are common.
    task automatic draw_id(input logic [31:0] base, output logic [31:0] id);
        logic [31:0] r;
        draw_bits(3, r);
        id = base;
        if (r == 0) begin
            draw_bits(2, r);
            id = pick_id(r[1:0]);
        end
    endtask

    task automatic test_random(input int count);
        logic [31:0] r;
        logic [31:0] id0;
        logic [31:0] id1;
        logic [31:0] addr_id;
        logic [31:0] cmd_id;
        logic [31:0] fuse_addr;
        logic [3:0]  cmd_bits;
        logic        send1;
        logic        expected;
        int          hold;
        for (int n = 0; n < count; n++) begin
            draw_bits(2, r);
            draw_id(pick_id(r[1:0]), id0);
            draw_id(id0, id1);
            draw_id(id0, addr_id);
            draw_id(id0, cmd_id);
            draw_bits(1, r);
            if (r[0]) begin
                draw_bits(6, r);
                fuse_addr = 32'h040 + r;
            end else begin
                draw_bits(10, r);
                fuse_addr = r;
            end
            draw_bits(3, r);
            case (r[2:0])
                3'd0:    cmd_bits = CMD_READ;
                3'd2:    cmd_bits = CMD_DIGEST;
                3'd3:    cmd_bits = CMD_ZEROIZE;
                3'd4:    cmd_bits = 4'h0;
                3'd5:    cmd_bits = 4'h3;
                default: cmd_bits = CMD_WRITE;
            endcase
            draw_bits(2, r);
            debug_mode = (r[1:0] == 2'b00);
            draw_bits(1, r);
            fips_zeroize = r[0];
            draw_bits(1, r);
            send1 = r[0];
            draw_bits(2, r);
            hold = int'(r[1:0]) + 1;
            expected = predict_discard(cmd_bits, fuse_addr, id0, send1 ? id1 : model_id1,
                                       addr_id, cmd_id);
            run_case($sformatf("random sequence %0d", n), fuse_addr, cmd_bits, id0, id1,
                     send1, addr_id, cmd_id, expected, hold);
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        init_done      = 1'b0;
        debug_mode     = 1'b0;
        fips_zeroize   = 1'b0;
        cptra_user     = CPTRA_ID;
        mcu_user       = MCU_ID;
        aw_valid       = 1'b0;
        aw_ready       = 1'b0;
        aw_addr        = '0;
        aw_user        = '0;
        w_valid        = 1'b0;
        w_ready        = 1'b0;
        w_data         = '0;
        discarded_fuse = 1'b0;
        lfsr_q         = 32'hd8f4_c3b8;
        model_id1      = '0;
        checks         = 0;
        errors         = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_allowed();
        test_table_violation();
        test_id_consistency();
        test_secret_rules();
        test_random(40);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
common/fuse_filter_pkg.sv
logic/dai_bus_decode.sv
logic/access_table_check.sv
fuse_filter/dai_id_records.sv
fuse_filter/dai_sequence_fsm.sv
fuse_filter/fuse_filter_top.sv
dv/fuse_filter_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := fuse_filter_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source file or the file list changes.
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
